//--- common/tod_macros.svh
//////////////////////////////
// Rates scaled for simulation, one clock domain only
//////////////////////////////
`ifndef TOD_MACROS_SVH
`define TOD_MACROS_SVH

// Link format
`define TOD_CLK_RATE      1000
`define TOD_SEC_WIDTH     32
`define TOD_FRAC_WIDTH    32
`define TOD_FRAC_WIDEN    12
`define TOD_FILTER_SHIFT  4
`define TOD_CNT_WIDTH     10

// Event codes
`define TOD_EV_SHIFT0     8'h70
`define TOD_EV_SHIFT1     8'h71
`define TOD_EV_MARKER     8'h7D

// Marker acceptance window, in clocks
`define TOD_WIN_EARLY     ((`TOD_CLK_RATE * 99) / 100)
`define TOD_WIN_SPAN      (`TOD_CLK_RATE / 50)

// Register map, one 32-bit word each
`define TOD_REG_STATUS    32'h00
`define TOD_REG_SECONDS   32'h04
`define TOD_REG_FRACTION  32'h08
`define TOD_REG_TOOFEW    32'h0C
`define TOD_REG_TOOMANY   32'h10
`define TOD_REG_OUTOFSEQ  32'h14

// AXI responses
`define TOD_RESP_OKAY     2'b00
`define TOD_RESP_SLVERR   2'b10

`endif

//--- common/todPkg.sv
//////////////////////////////
// AXI4-Lite fields fixed at 32-bit address and data
//////////////////////////////
`include "tod_macros.svh"

package todPkg;

    // One link event per clock
    typedef struct packed {
        logic [7:0] code;
        logic       valid;
    } evCodeT;

    typedef struct packed {
        logic [`TOD_SEC_WIDTH-1:0]  seconds;
        logic [`TOD_FRAC_WIDTH-1:0] fraction;
    } timestampT;

    // Packs into exactly one 32-bit status word
    typedef struct packed {
        logic                      timestampValid;
        logic                      ppsValid;
        logic [`TOD_CNT_WIDTH-1:0] tooFew;
        logic [`TOD_CNT_WIDTH-1:0] tooMany;
        logic [`TOD_CNT_WIDTH-1:0] outOfSeq;
    } todStatusT;

    // Master to slave
    typedef struct packed {
        logic [31:0] awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [31:0] araddr;
        logic        arvalid;
        logic        rready;
    } axilReqT;

    // Slave to master
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axilRspT;

endpackage

//--- hw/todReceiver/ppsMonitor.sv
//////////////////////////////
// Window is checked against the previous marker only
//////////////////////////////
`include "tod_macros.svh"

module ppsMonitor (
    input  logic           clk,
    input  logic           rst,
    input  todPkg::evCodeT ev,
    output logic           markerOk,
    output logic [10:0]    markerCount,
    output logic           ppsValid
);
    // Down counters carry a sign bit that flags expiry
    localparam int earlyWidth = $clog2(`TOD_WIN_EARLY) + 1;
    localparam int spanWidth = $clog2(`TOD_WIN_SPAN) + 1;

    logic                  marker;
    logic [10:0]           clockCount;
    logic [earlyWidth-1:0] earlyLeft;
    logic [spanWidth-1:0]  windowLeft;
    logic                  earlyDone;
    logic                  windowDone;
    logic                  inWindow;
    logic [2:0]            qualCount;

    assign marker = ev.valid && (ev.code == `TOD_EV_MARKER);
    assign earlyDone = earlyLeft[earlyWidth-1];
    assign windowDone = windowLeft[spanWidth-1];
    assign inWindow = earlyDone && !windowDone;
    assign ppsValid = qualCount[2];

    //////////////////////////////
    // Interval and window counters
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            clockCount <= '0;
            earlyLeft <= '1;
            windowLeft <= '1;
            qualCount <= '0;
            markerOk <= 1'b0;
        end else begin
            markerOk <= marker && inWindow;
            if (marker) begin
                clockCount <= 11'd1;
                earlyLeft <= earlyWidth'(`TOD_WIN_EARLY - 1);
                windowLeft <= spanWidth'(`TOD_WIN_SPAN - 1);
                // Early or late marker restarts qualification
                if (!inWindow) begin
                    qualCount <= '0;
                end else if (!ppsValid) begin
                    qualCount <= qualCount + 1'b1;
                end
            end else begin
                clockCount <= clockCount + 1'b1;
                if (!earlyDone) begin
                    earlyLeft <= earlyLeft - 1'b1;
                end else if (!windowDone) begin
                    windowLeft <= windowLeft - 1'b1;
                end else begin
                    // Window ran out with no marker
                    qualCount <= '0;
                end
            end
        end
    end

    // Interval length, read together with markerOk
    always_ff @(posedge clk) begin
        if (marker) begin
            markerCount <= clockCount;
        end
    end

endmodule

//--- hw/todReceiver/fractionGenerator.sv
//////////////////////////////
// Rate must stay above half of 2^10 clocks for the divider
//////////////////////////////
`include "tod_macros.svh"

module fractionGenerator (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       markerOk,
    input  logic [10:0]                markerCount,
    input  todPkg::evCodeT             ev,
    output logic [`TOD_FRAC_WIDTH-1:0] fraction,
    output logic                       fracOverflow
);
    localparam int rateWidth = 11;
    localparam int filterWidth = rateWidth + `TOD_FILTER_SHIFT;
    localparam int accWidth = `TOD_FRAC_WIDTH + `TOD_FRAC_WIDEN;
    // Quotient bits of 2^accWidth over a rate above 2^(rateWidth-2)
    localparam int incWidth = accWidth - rateWidth + 2;
    localparam int stepWidth = $clog2(incWidth) + 1;
    localparam logic [filterWidth-1:0] filterSeed =
        filterWidth'(`TOD_CLK_RATE << `TOD_FILTER_SHIFT);
    localparam logic [incWidth-1:0] incSeed =
        incWidth'((64'd1 << accWidth) / `TOD_CLK_RATE);
    localparam logic [rateWidth:0] remSeed = 1 << (rateWidth - 1);

    logic                   marker;
    logic [filterWidth-1:0] filterAcc;
    logic [rateWidth-1:0]   filteredRate;
    logic                   divStart;
    logic                   divRun;
    logic [stepWidth-1:0]   stepsLeft;
    logic                   divDone;
    logic [rateWidth:0]     remainder;
    logic [incWidth-1:0]    quotient;
    logic [incWidth-1:0]    pendingInc;
    logic [incWidth-1:0]    increment;
    logic [accWidth-1:0]    fracAcc;
    logic [accWidth:0]      accSum;

    assign marker = ev.valid && (ev.code == `TOD_EV_MARKER);
    assign filteredRate = filterAcc[filterWidth-1 -: rateWidth];
    assign divDone = stepsLeft[stepWidth-1];

    //////////////////////////////
    // Rate filter and divider control
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            filterAcc <= filterSeed;
            divStart <= 1'b0;
            divRun <= 1'b0;
            stepsLeft <= '1;
            pendingInc <= incSeed;
            increment <= incSeed;
        end else begin
            divStart <= markerOk;
            if (markerOk) begin
                filterAcc <= filterAcc - (filterAcc >> `TOD_FILTER_SHIFT)
                             + filterWidth'(markerCount);
            end
            if (divStart) begin
                stepsLeft <= stepWidth'(incWidth - 1);
                divRun <= 1'b1;
            end else if (!divDone) begin
                stepsLeft <= stepsLeft - 1'b1;
            end else if (divRun) begin
                pendingInc <= quotient;
                divRun <= 1'b0;
            end
            // New increment takes effect at the next second
            if (marker) begin
                increment <= pendingInc;
            end
        end
    end

    // Restoring division, one quotient bit per clock
    always_ff @(posedge clk) begin
        if (divStart) begin
            remainder <= remSeed;
        end else if (!divDone) begin
            if (remainder >= {1'b0, filteredRate}) begin
                remainder <= (remainder - {1'b0, filteredRate}) << 1;
                quotient <= {quotient[incWidth-2:0], 1'b1};
            end else begin
                remainder <= remainder << 1;
                quotient <= {quotient[incWidth-2:0], 1'b0};
            end
        end
    end

    //////////////////////////////
    // Fraction accumulator
    //////////////////////////////
    assign accSum = {1'b0, fracAcc} + (accWidth + 1)'(increment);
    assign fraction = fracAcc[accWidth-1 -: `TOD_FRAC_WIDTH];
    assign fracOverflow = &fracAcc;

    always_ff @(posedge clk) begin
        if (rst || marker) begin
            fracAcc <= '0;
        end else if (accSum[accWidth]) begin
            fracAcc <= '1;
        end else begin
            fracAcc <= accSum[accWidth-1:0];
        end
    end

endmodule

//--- hw/todReceiver/secondsReceiver.sv
//////////////////////////////
// Seconds value arrives MSB first before its marker
//////////////////////////////
`include "tod_macros.svh"

module secondsReceiver (
    input  logic                      clk,
    input  logic                      rst,
    input  todPkg::evCodeT            ev,
    input  logic                      ppsValid,
    input  logic                      fracOverflow,
    output logic [`TOD_SEC_WIDTH-1:0] seconds,
    output logic                      timestampValid,
    output logic [`TOD_CNT_WIDTH-1:0] tooFew,
    output logic [`TOD_CNT_WIDTH-1:0] tooMany,
    output logic [`TOD_CNT_WIDTH-1:0] outOfSeq
);
    localparam int bitsWidth = $clog2(`TOD_SEC_WIDTH);

    logic                      marker;
    logic                      shiftBit;
    logic [`TOD_SEC_WIDTH-1:0] shiftReg;
    logic [`TOD_SEC_WIDTH-1:0] expectSeconds;
    logic [bitsWidth-1:0]      bitsLeft;
    logic                      enoughBits;
    logic                      tooManyBits;
    logic                      framed;
    logic                      secondsValid;

    assign marker = ev.valid && (ev.code == `TOD_EV_MARKER);
    assign shiftBit = ev.valid
                      && ((ev.code == `TOD_EV_SHIFT0) || (ev.code == `TOD_EV_SHIFT1));
    assign framed = enoughBits && !tooManyBits;
    assign timestampValid = secondsValid && ppsValid;

    // Code bit 0 carries the seconds bit
    always_ff @(posedge clk) begin
        if (shiftBit) begin
            shiftReg <= {shiftReg[`TOD_SEC_WIDTH-2:0], ev.code[0]};
        end
    end

    //////////////////////////////
    // Bit framing
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst || marker) begin
            bitsLeft <= bitsWidth'(`TOD_SEC_WIDTH - 1);
            enoughBits <= 1'b0;
            tooManyBits <= 1'b0;
        end else if (shiftBit) begin
            bitsLeft <= bitsLeft - 1'b1;
            if (enoughBits) begin
                tooManyBits <= 1'b1;
            end
            if (bitsLeft == '0) begin
                enoughBits <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // Sequence check and counters
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            seconds <= '0;
            expectSeconds <= '0;
            secondsValid <= 1'b0;
            tooFew <= '0;
            tooMany <= '0;
            outOfSeq <= '0;
        end else if (marker) begin
            if (framed) begin
                expectSeconds <= shiftReg + 1'b1;
                if (shiftReg == expectSeconds) begin
                    seconds <= shiftReg;
                    secondsValid <= 1'b1;
                end else begin
                    outOfSeq <= outOfSeq + 1'b1;
                    if (secondsValid) begin
                        seconds <= seconds + 1'b1;
                    end
                end
            end else begin
                if (!enoughBits) begin
                    tooFew <= tooFew + 1'b1;
                end else begin
                    tooMany <= tooMany + 1'b1;
                end
                // Value lost, keep counting on our own
                expectSeconds <= expectSeconds + 1'b1;
                if (secondsValid) begin
                    seconds <= seconds + 1'b1;
                end
            end
        end else if (fracOverflow) begin
            secondsValid <= 1'b0;
        end
    end

endmodule

//--- hw/todReceiver/todReceiver.sv
//////////////////////////////
// Timestamp valid only after four in-window markers
//////////////////////////////
`include "tod_macros.svh"

module todReceiver (
    input  logic              clk,
    input  logic              rst,
    input  todPkg::evCodeT    ev,
    output todPkg::timestampT timestamp,
    output todPkg::todStatusT status
);
    logic                       markerOk;
    logic [10:0]                markerCount;
    logic                       ppsValid;
    logic                       fracOverflow;
    logic [`TOD_FRAC_WIDTH-1:0] fraction;
    logic [`TOD_SEC_WIDTH-1:0]  seconds;
    logic                       timestampValid;
    logic [`TOD_CNT_WIDTH-1:0]  tooFew;
    logic [`TOD_CNT_WIDTH-1:0]  tooMany;
    logic [`TOD_CNT_WIDTH-1:0]  outOfSeq;

    ppsMonitor ppsMonitor_inst (
        .clk         (clk),
        .rst         (rst),
        .ev          (ev),
        .markerOk    (markerOk),
        .markerCount (markerCount),
        .ppsValid    (ppsValid)
    );

    fractionGenerator fractionGenerator_inst (
        .clk          (clk),
        .rst          (rst),
        .markerOk     (markerOk),
        .markerCount  (markerCount),
        .ev           (ev),
        .fraction     (fraction),
        .fracOverflow (fracOverflow)
    );

    secondsReceiver secondsReceiver_inst (
        .clk            (clk),
        .rst            (rst),
        .ev             (ev),
        .ppsValid       (ppsValid),
        .fracOverflow   (fracOverflow),
        .seconds        (seconds),
        .timestampValid (timestampValid),
        .tooFew         (tooFew),
        .tooMany        (tooMany),
        .outOfSeq       (outOfSeq)
    );

    assign timestamp.seconds = seconds;
    assign timestamp.fraction = fraction;
    assign status.timestampValid = timestampValid;
    assign status.ppsValid = ppsValid;
    assign status.tooFew = tooFew;
    assign status.tooMany = tooMany;
    assign status.outOfSeq = outOfSeq;

endmodule

//--- hw/todStatusRegs.sv
//////////////////////////////
// Read-only, every write gets SLVERR
// Read seconds before fraction for a consistent pair
//////////////////////////////
`include "tod_macros.svh"

module todStatusRegs (
    input  logic              clk,
    input  logic              rst,
    input  todPkg::timestampT timestamp,
    input  todPkg::todStatusT status,
    input  todPkg::axilReqT   axilReq,
    output todPkg::axilRspT   axilRsp
);
    logic        readAccept;
    logic        writeAccept;
    logic        readHit;
    logic [31:0] readWord;
    logic [31:0] fracSnap;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        bvalid;

    // One read outstanding at a time
    assign readAccept = axilReq.arvalid && !rvalid;
    // Address and data taken in the same cycle
    assign writeAccept = axilReq.awvalid && axilReq.wvalid && !bvalid;

    //////////////////////////////
    // Address decode
    //////////////////////////////
    always_comb begin
        readHit = 1'b1;
        case (axilReq.araddr)
            `TOD_REG_STATUS:   readWord = status;
            `TOD_REG_SECONDS:  readWord = timestamp.seconds;
            `TOD_REG_FRACTION: readWord = fracSnap;
            `TOD_REG_TOOFEW:   readWord = 32'(status.tooFew);
            `TOD_REG_TOOMANY:  readWord = 32'(status.tooMany);
            `TOD_REG_OUTOFSEQ: readWord = 32'(status.outOfSeq);
            default: begin
                readWord = '0;
                readHit = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
            bvalid <= 1'b0;
            fracSnap <= '0;
        end else begin
            if (readAccept) begin
                rvalid <= 1'b1;
            end else if (axilReq.rready) begin
                rvalid <= 1'b0;
            end
            if (writeAccept) begin
                bvalid <= 1'b1;
            end else if (axilReq.bready) begin
                bvalid <= 1'b0;
            end
            // Fraction of the same cycle as the seconds read
            if (readAccept && (axilReq.araddr == `TOD_REG_SECONDS)) begin
                fracSnap <= timestamp.fraction;
            end
        end
    end

    // Read response payload
    always_ff @(posedge clk) begin
        if (readAccept) begin
            rdata <= readWord;
            rresp <= readHit ? `TOD_RESP_OKAY : `TOD_RESP_SLVERR;
        end
    end

    assign axilRsp.awready = writeAccept;
    assign axilRsp.wready = writeAccept;
    assign axilRsp.bresp = `TOD_RESP_SLVERR;
    assign axilRsp.bvalid = bvalid;
    assign axilRsp.arready = !rvalid;
    assign axilRsp.rdata = rdata;
    assign axilRsp.rresp = rresp;
    assign axilRsp.rvalid = rvalid;

endmodule

//--- hw/todTop.sv
//////////////////////////////
// Link and register bus share clk
//////////////////////////////
module todTop (
    input  logic              clk,
    input  logic              rst,
    input  todPkg::evCodeT    ev,
    input  todPkg::axilReqT   axilReq,
    output todPkg::axilRspT   axilRsp,
    output todPkg::timestampT timestamp,
    output todPkg::todStatusT status
);
    todReceiver todReceiver_inst (
        .clk       (clk),
        .rst       (rst),
        .ev        (ev),
        .timestamp (timestamp),
        .status    (status)
    );

    // Register view of the same timestamp and status
    todStatusRegs todStatusRegs_inst (
        .clk       (clk),
        .rst       (rst),
        .timestamp (timestamp),
        .status    (status),
        .axilReq   (axilReq),
        .axilRsp   (axilRsp)
    );

endmodule

//--- verif/todTop_chk.sv
//////////////////////////////
// Bound into todTop, sees only its top-level ports
//////////////////////////////
`include "tod_macros.svh"

module todTop_chk (
    input logic              clk,
    input logic              rst,
    input todPkg::axilReqT   axilReq,
    input todPkg::axilRspT   axilRsp,
    input todPkg::timestampT timestamp,
    input todPkg::todStatusT status
);
    // Number of failed assertions
    int failCount = 0;

    // Read response is held until the master takes it
    rvalidHold: assert property (
        @(posedge clk) disable iff (rst)
        axilRsp.rvalid && !axilReq.rready |=> axilRsp.rvalid && $stable(axilRsp.rdata)
    ) else begin
        failCount++;
        $error("rvalid or rdata changed before rready");
    end

    // A refused write waits for bready
    writeRefused: assert property (
        @(posedge clk) disable iff (rst)
        axilRsp.bvalid && !axilReq.bready
            |=> axilRsp.bvalid && (axilRsp.bresp == `TOD_RESP_SLVERR)
    ) else begin
        failCount++;
        $error("write response dropped before bready or is not SLVERR");
    end

    // Timestamp turns valid at a second boundary with a qualified PPS
    validAtSecond: assert property (
        @(posedge clk) disable iff (rst)
        $rose(status.timestampValid) |-> status.ppsValid && (timestamp.fraction == '0)
    ) else begin
        failCount++;
        $error("timestampValid rose without ppsValid or off a second boundary");
    end

endmodule

//--- verif/todTop_tb.sv
//////////////////////////////
// Intervals stay at 999 or 1000 clocks except the one early test
//////////////////////////////
`include "tod_macros.svh"

module todTop_tb;
    localparam int timeoutLimit = 12 * `TOD_CLK_RATE + 2000;
    localparam logic [63:0] fracOne = 64'd1 << (`TOD_FRAC_WIDTH + `TOD_FRAC_WIDEN);

    logic              clk = 1'b0;
    logic              rst;
    todPkg::evCodeT    ev;
    todPkg::axilReqT   axilReq;
    todPkg::axilRspT   axilRsp;
    todPkg::timestampT timestamp;
    todPkg::todStatusT status;
    integer            seed;
    integer            busSeed;
    int                cycles = 0;

    // Reference model state
    bit          havePrev, fracKnown, secValid;
    int          sinceMarker, fracAge, qual, bitCount;
    int          tooFewM, tooManyM, outOfSeqM;
    logic [63:0] filterAcc, pending, inc;
    logic [31:0] shiftVal, expectSec, modelSec;

    // Bus master state
    int          busState;
    bit          busOn, readFrac;
    logic [31:0] expRead, snapExp;

    todTop todTop_inst (
        .clk       (clk),
        .rst       (rst),
        .ev        (ev),
        .axilReq   (axilReq),
        .axilRsp   (axilRsp),
        .timestamp (timestamp),
        .status    (status)
    );

    bind todTop todTop_chk chk_inst (
        .clk       (clk),
        .rst       (rst),
        .axilReq   (axilReq),
        .axilRsp   (axilRsp),
        .timestamp (timestamp),
        .status    (status)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > timeoutLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutLimit);
            $display("=== FAIL ===");
            $fatal(1, "stopped on timeout");
        end
    end

    // Bound assertions count their failures
    always @(negedge clk) begin
        if (todTop_inst.chk_inst.failCount != 0) begin
            $display("A bound assertion failed, see the assertion message above");
            $display("=== FAIL ===");
            $fatal(1, "stopped on assertion failure");
        end
    end

    task automatic check(input string name, input logic [63:0] expVal, input logic [63:0] actVal);
        if (expVal !== actVal) begin
            $display("[ERROR] %s expected %h actual %h", name, expVal, actVal);
            $display("=== FAIL ===");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // Top 32 bits of k times the increment, saturating
    function automatic logic [31:0] modelFraction();
        logic [63:0] acc;
        acc = 64'(fracAge) * inc;
        if (acc >= fracOne) begin
            acc = fracOne - 1;
        end
        return acc[`TOD_FRAC_WIDTH+`TOD_FRAC_WIDEN-1 -: `TOD_FRAC_WIDTH];
    endfunction

    task automatic compareOutputs();
        check("seconds", modelSec, timestamp.seconds);
        check("timestampValid", secValid && (qual >= 4), status.timestampValid);
        check("ppsValid", qual >= 4, status.ppsValid);
        check("tooFew", tooFewM, status.tooFew);
        check("tooMany", tooManyM, status.tooMany);
        check("outOfSeq", outOfSeqM, status.outOfSeq);
        if (fracKnown && (($random(seed) & 7) == 0)) begin
            check("fraction", modelFraction(), timestamp.fraction);
        end
    endtask

    //////////////////////////////
    // Marker effect on the model
    //////////////////////////////
    task automatic markerModel();
        bit inWin;
        inWin = havePrev && (sinceMarker > `TOD_WIN_EARLY)
                && (sinceMarker <= `TOD_WIN_EARLY + `TOD_WIN_SPAN);
        if (!inWin) begin
            qual = 0;
        end else if (qual < 4) begin
            qual++;
        end
        // New rate applies from the next second
        inc = pending;
        if (inWin) begin
            filterAcc = filterAcc - (filterAcc >> `TOD_FILTER_SHIFT) + sinceMarker;
            pending = fracOne / (filterAcc >> `TOD_FILTER_SHIFT);
        end
        if (bitCount == 32) begin
            if (shiftVal == expectSec) begin
                modelSec = shiftVal;
                secValid = 1'b1;
            end else begin
                outOfSeqM++;
                if (secValid) begin
                    modelSec++;
                end
            end
            expectSec = shiftVal + 1;
        end else begin
            if (bitCount < 32) begin
                tooFewM++;
            end else begin
                tooManyM++;
            end
            expectSec++;
            if (secValid) begin
                modelSec++;
            end
        end
        bitCount = 0;
        fracAge = -1;
        fracKnown = 1'b1;
        havePrev = 1'b1;
        sinceMarker = 0;
    endtask

    // Seconds read then fraction read, random rready
    task automatic busStep();
        case (busState)
            0: begin
                axilReq.rready = 1'b0;
                if (busOn) begin
                    axilReq.araddr = readFrac ? `TOD_REG_FRACTION : `TOD_REG_SECONDS;
                    axilReq.arvalid = 1'b1;
                    busState = 1;
                end
            end
            2: begin
                axilReq.arvalid = 1'b0;
                axilReq.rready = $random(busSeed) & 1;
                if (axilRsp.rvalid && axilReq.rready) begin
                    check(readFrac ? "fractionRead" : "secondsRead", expRead, axilRsp.rdata);
                    check("readResp", `TOD_RESP_OKAY, axilRsp.rresp);
                    readFrac = !readFrac;
                    busState = 0;
                end
            end
            default: ;
        endcase
        // Accepted at the coming edge
        if (busState == 1 && axilRsp.arready) begin
            if (!readFrac) begin
                expRead = modelSec;
                snapExp = modelFraction();
            end else begin
                expRead = snapExp;
            end
            busState = 2;
        end
    endtask

    task automatic cycle(input logic [7:0] code, input logic valid);
        @(negedge clk);
        sinceMarker++;
        fracAge++;
        compareOutputs();
        busStep();
        ev.code = code;
        ev.valid = valid;
        if (valid && (code == `TOD_EV_SHIFT0 || code == `TOD_EV_SHIFT1)) begin
            shiftVal = {shiftVal[30:0], code[0]};
            bitCount++;
        end
        if (valid && code == `TOD_EV_MARKER) begin
            markerModel();
        end
    endtask

    // Filler never carries a valid one of the three codes
    task automatic filler();
        logic [8:0] r;
        r = $random(seed);
        if (r[8] && (r[7:0] inside {`TOD_EV_SHIFT0, `TOD_EV_SHIFT1, `TOD_EV_MARKER})) begin
            r[3] = !r[3];
        end
        cycle(r[7:0], r[8]);
    endtask

    task automatic sendSecond(input logic [31:0] value, input int nbits, input int gap);
        int idx;
        logic bitVal;
        for (int i = 0; i < gap - 1; i++) begin
            if (i < nbits) begin
                idx = nbits - 1 - i;
                bitVal = (idx < 32) ? value[idx] : 1'b0;
                cycle({7'b0111000, bitVal}, 1'b1);
            end else begin
                filler();
            end
        end
        cycle(`TOD_EV_MARKER, 1'b1);
    endtask

    task automatic readDirect(input logic [31:0] addr, input logic [31:0] expData,
                              input logic [1:0] expResp, input string name);
        @(negedge clk);
        axilReq.araddr = addr;
        axilReq.arvalid = 1'b1;
        axilReq.rready = 1'b1;
        check("arready", 1, axilRsp.arready);
        do @(negedge clk); while (!axilRsp.rvalid);
        check(name, expData, axilRsp.rdata);
        check({name, "Resp"}, expResp, axilRsp.rresp);
        check("arreadyBusy", 0, axilRsp.arready);
        axilReq.arvalid = 1'b0;
        @(negedge clk);
        axilReq.rready = 1'b0;
    endtask

    task automatic writeDirect();
        @(negedge clk);
        axilReq.awaddr = `TOD_REG_TOOFEW;
        axilReq.wdata = 32'h0000_0155;
        axilReq.wstrb = 4'hF;
        axilReq.awvalid = 1'b1;
        axilReq.wvalid = 1'b1;
        axilReq.bready = 1'b0;
        #1;
        check("writeReady", 2'b11, {axilRsp.awready, axilRsp.wready});
        do @(negedge clk); while (!axilRsp.bvalid);
        axilReq.awvalid = 1'b0;
        axilReq.wvalid = 1'b0;
        // Response must wait for bready
        @(negedge clk);
        check("writeHold", 1, axilRsp.bvalid);
        check("writeResp", `TOD_RESP_SLVERR, axilRsp.bresp);
        axilReq.bready = 1'b1;
        @(negedge clk);
        axilReq.bready = 1'b0;
        check("writeDone", 0, axilRsp.bvalid);
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial begin
        seed = 32'h1c417ace;
        busSeed = seed ^ 32'h0000_ffff;
        rst = 1'b1;
        ev = '0;
        axilReq = '0;
        filterAcc = `TOD_CLK_RATE << `TOD_FILTER_SHIFT;
        pending = fracOne / `TOD_CLK_RATE;
        inc = pending;
        {havePrev, fracKnown, secValid, busOn, readFrac} = '0;
        {sinceMarker, fracAge, qual, bitCount, busState} = '0;
        {tooFewM, tooManyM, outOfSeqM} = '0;
        shiftVal = '0;
        expectSec = '0;
        modelSec = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Idle state after reset
        readDirect(`TOD_REG_STATUS, 32'h0, `TOD_RESP_OKAY, "status");
        readDirect(`TOD_REG_TOOFEW, 32'h0, `TOD_RESP_OKAY, "tooFewReg");
        readDirect(`TOD_REG_TOOMANY, 32'h0, `TOD_RESP_OKAY, "tooManyReg");
        readDirect(`TOD_REG_OUTOFSEQ, 32'h0, `TOD_RESP_OKAY, "outOfSeqReg");
        readDirect(32'h18, 32'h0, `TOD_RESP_SLVERR, "unmapped");
        writeDirect();

        // Lock on four in-window markers
        sendSecond(32'd0, 32, 100);
        for (int s = 1; s <= 4; s++) begin
            sendSecond(s, 32, `TOD_CLK_RATE);
        end
        cycle(8'h00, 1'b0);
        check("lockValid", 1, status.timestampValid);

        // Framing and sequence errors with jitter and bus traffic
        busOn = 1'b1;
        sendSecond(32'd5, 31, `TOD_CLK_RATE - ($random(seed) & 1));
        sendSecond(32'd6, 33, `TOD_CLK_RATE - ($random(seed) & 1));
        sendSecond(32'd200, 32, `TOD_CLK_RATE - ($random(seed) & 1));

        // Early marker drops lock, four good intervals restore it
        sendSecond(32'd201, 32, 980);
        cycle(8'h00, 1'b0);
        check("earlyDrop", 0, status.timestampValid);
        for (int s = 202; s <= 205; s++) begin
            sendSecond(s, 32, `TOD_CLK_RATE);
        end
        cycle(8'h00, 1'b0);
        check("relockValid", 1, status.timestampValid);
        check("relockSeconds", 205, timestamp.seconds);

        busOn = 1'b0;
        while (busState != 0) begin
            cycle(8'h00, 1'b0);
        end
        cycle(8'h00, 1'b0);

        if (todTop_inst.chk_inst.failCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+common
common/todPkg.sv
hw/todReceiver/ppsMonitor.sv
hw/todReceiver/fractionGenerator.sv
hw/todReceiver/secondsReceiver.sv
hw/todReceiver/todReceiver.sv
hw/todStatusRegs.sv
hw/todTop.sv
verif/todTop_chk.sv
verif/todTop_tb.sv
